/* source/armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ====================
  // Instruction fields
  // ====================
  localparam int instrWidth = 32;
  localparam int condMsb    = 31;  // Condition code
  localparam int condLsb    = 28;
  localparam int immBit     = 25;  // Immediate or register operand
  localparam int opMsb      = 24;  // Data processing opcode
  localparam int opLsb      = 21;
  localparam int upBit      = 23;  // Offset added when set
  localparam int byteBit    = 22;  // Byte access for LDR/STR
  localparam int sBit       = 20;  // Set flags on data processing
  localparam int loadBit    = 20;  // Load on LDR/STR
  localparam int rdMsb      = 15;  // Destination register
  localparam int rdLsb      = 12;
  localparam int pcReg      = 15;  // r15 is the PC

  // ====================
  // Encodings
  // ====================
  // Data processing opcodes in instruction order
  typedef enum logic [3:0] {
    andOp = 4'h0, eorOp, subOp, rsbOp,
    addOp, adcOp, sbcOp, rscOp,
    tstOp, teqOp, cmpOp, cmnOp,
    orrOp, movOp, bicOp, mvnOp
  } aluOpT;

  // Condition field values
  typedef enum logic [3:0] {
    eq = 4'h0, ne, cs, cc,
    mi, pl, vs, vc,
    hi, ls, ge, lt,
    gt, le, al, nv
  } condT;

  typedef struct packed {
    logic n;  // Negative
    logic z;  // Zero
    logic c;  // Carry
    logic v;  // Overflow
  } flagsT;

endpackage

`default_nettype wire

/* source/instrDecoder.sv */
`default_nettype none

module instrDecoder
  import armCtrlPkg::*;
(
  input  logic [instrWidth-1:0] instrD,
  output logic [1:0]            regSrcD,
  output logic [1:0]            immSrcD,
  output logic                  aluSrcD,
  output logic                  memtoRegD,
  output logic                  regWriteD,
  output logic                  memWriteD,
  output logic                  branchD,
  output logic                  pcSrcD,
  output logic                  flagWriteD,
  output logic                  byteD,
  output aluOpT                 aluControlD
);

  logic [2:0] classD;    // Bits 27:25
  logic [3:0] rdD;       // Destination register field
  logic       dpD;       // Data processing class
  logic       ldStD;     // Single LDR/STR
  logic       cmpOnlyD;  // tst, teq, cmp, cmn

  assign classD   = instrD[27:25];
  assign rdD      = instrD[rdMsb:rdLsb];
  assign cmpOnlyD = (instrD[opMsb -: 2] == 2'b10);  // Opcodes 10xx leave rd alone

  // ====================
  // Class decode
  // ====================
  always_comb begin
    regSrcD   = 2'b00;  // Everything off unless a class claims it
    immSrcD   = 2'b00;
    aluSrcD   = 1'b0;
    memtoRegD = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    branchD   = 1'b0;
    dpD       = 1'b0;
    ldStD     = 1'b0;
    case (classD)
      3'b000, 3'b001: begin  // DP register (multiply lands here too) and DP immediate
        dpD       = 1'b1;
        aluSrcD   = instrD[immBit];
        regWriteD = ~cmpOnlyD;
      end
      3'b010, 3'b011: begin  // LDR/STR, immediate or register offset
        // Register offset with bit 4 set is the undefined space
        if (!(instrD[immBit] && instrD[4])) begin
          ldStD   = 1'b1;
          immSrcD = 2'b01;             // 12-bit offset
          aluSrcD = ~instrD[immBit];   // Bit 25 clear means immediate here
          if (instrD[loadBit]) begin
            memtoRegD = 1'b1;
            regWriteD = 1'b1;
          end else begin
            regSrcD   = 2'b10;         // Read rd as store data
            memWriteD = 1'b1;
          end
        end
      end
      3'b101: begin  // B
        regSrcD = 2'b01;  // PC as first operand
        immSrcD = 2'b10;  // 24-bit word offset
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;  // LDM/STM, coprocessor and SWI do nothing
    endcase
  end

  // ====================
  // ALU opcode
  // ====================
  always_comb begin
    if (dpD) begin
      aluControlD = aluOpT'(instrD[opMsb:opLsb]);
    end else if (ldStD && !instrD[upBit]) begin
      aluControlD = subOp;  // Base minus offset
    end else begin
      aluControlD = addOp;  // Base plus offset, branch target
    end
  end

  assign flagWriteD = dpD & instrD[sBit];
  assign byteD      = ldStD & instrD[byteBit];  // STRB/LDRB
  // Branches and any write to r15 redirect fetch
  assign pcSrcD     = branchD | (regWriteD & (rdD == 4'(pcReg)));

endmodule

`default_nettype wire

/* source/condUnit.sv */
`default_nettype none

module condUnit
  import armCtrlPkg::*;
(
  input  condT  cond,
  input  flagsT flags,
  input  flagsT aluFlags,
  input  aluOpT aluControl,
  input  logic  flagWrite,
  output logic  condEx,
  output flagsT flagsNext
);

  logic nEqV;     // Signed compare helper
  logic arithOp;  // Opcode produces its own C and V

  assign nEqV = (flags.n == flags.v);

  // ====================
  // Condition table
  // ====================
  always_comb begin
    case (cond)
      eq:      condEx = flags.z;
      ne:      condEx = ~flags.z;
      cs:      condEx = flags.c;
      cc:      condEx = ~flags.c;
      mi:      condEx = flags.n;
      pl:      condEx = ~flags.n;
      vs:      condEx = flags.v;
      vc:      condEx = ~flags.v;
      hi:      condEx = flags.c & ~flags.z;   // Unsigned higher
      ls:      condEx = ~flags.c | flags.z;   // Unsigned lower or same
      ge:      condEx = nEqV;
      lt:      condEx = ~nEqV;
      gt:      condEx = ~flags.z & nEqV;
      le:      condEx = flags.z | ~nEqV;
      al:      condEx = 1'b1;
      default: condEx = 1'b0;                 // nv never executes
    endcase
  end

  always_comb begin
    case (aluControl)
      subOp, rsbOp, addOp, adcOp, sbcOp, rscOp, cmpOp, cmnOp: arithOp = 1'b1;
      default: arithOp = 1'b0;
    endcase
  end

  // ====================
  // Next flags
  // ====================
  always_comb begin
    flagsNext = flags;  // Hold unless S bit set
    if (flagWrite) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
      // Logical ops keep C and V with no shifter carry in this core
      if (arithOp) begin
        flagsNext.c = aluFlags.c;
        flagsNext.v = aluFlags.v;
      end
    end
  end

endmodule

`default_nettype wire

/* source/executeStage.sv */
`default_nettype none

module executeStage
  import armCtrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallD,
  input  logic       flushD,
  input  logic       stallE,
  input  logic       flushE,
  input  logic       memtoRegD,
  input  logic       regWriteD,
  input  logic       memWriteD,
  input  logic       branchD,
  input  logic       pcSrcD,
  input  logic       flagWriteD,
  input  logic       byteD,
  input  aluOpT      aluControlD,
  input  condT       condD,
  input  flagsT      aluFlagsE,
  input  logic [1:0] aluResultLowE,
  input  flagsT      flagsM,
  input  flagsT      flagsW,
  input  flagsT      cpsrFlags,
  input  logic       setFlagsM,
  input  logic       setFlagsW,
  output aluOpT      aluControlE,
  output logic       branchTakenE,
  output logic       memtoRegE,
  output logic       regWriteGE,
  output logic       memWriteGE,
  output logic       pcSrcGE,
  output logic       setFlagsE,
  output flagsT      flagsNextE,
  output logic [3:0] byteMaskE
);

  logic  killD;           // Decode slot holds a flushed bubble
  logic  memtoRegRawE;
  logic  regWriteRawE;
  logic  memWriteRawE;
  logic  branchRawE;
  logic  pcSrcRawE;
  logic  flagWriteRawE;
  logic  byteE;
  condT  condE;
  flagsT flagsE;          // Forwarded flags
  logic  condExE;

  // Datapath zeroes the Decode register on flushD, and that word must not write
  always_ff @(posedge clk) begin
    if (!rstN) begin
      killD <= 1'b0;
    end else if (flushD) begin
      killD <= 1'b1;
    end else if (!stallD) begin
      killD <= 1'b0;
    end
  end

  // ====================
  // Execute register
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin  // Flush wins over stall
      memtoRegRawE  <= 1'b0;
      regWriteRawE  <= 1'b0;
      memWriteRawE  <= 1'b0;
      branchRawE    <= 1'b0;
      pcSrcRawE     <= 1'b0;
      flagWriteRawE <= 1'b0;
      byteE         <= 1'b0;
      aluControlE   <= andOp;
      condE         <= eq;      // Encoding zero
    end else if (!stallE) begin
      memtoRegRawE  <= memtoRegD & ~killD;
      regWriteRawE  <= regWriteD & ~killD;
      memWriteRawE  <= memWriteD & ~killD;
      branchRawE    <= branchD & ~killD;
      pcSrcRawE     <= pcSrcD & ~killD;
      flagWriteRawE <= flagWriteD & ~killD;
      byteE         <= byteD;
      aluControlE   <= aluControlD;
      condE         <= condD;
    end
  end

  // Youngest pending flag setter first
  assign flagsE = setFlagsM ? flagsM : (setFlagsW ? flagsW : cpsrFlags);

  condUnit condI (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .aluControl(aluControlE),
    .flagWrite (flagWriteRawE),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  // ====================
  // Condition gating
  // ====================
  assign branchTakenE = branchRawE & condExE;
  assign memtoRegE    = memtoRegRawE & condExE;  // No load issued on a failed condition
  assign regWriteGE   = regWriteRawE & condExE;
  assign memWriteGE   = memWriteRawE & condExE;
  assign pcSrcGE      = pcSrcRawE & condExE;
  assign setFlagsE    = flagWriteRawE & condExE;

  // Byte lanes for the store, address bits pick the lane
  always_comb begin
    if (!memWriteGE) begin
      byteMaskE = 4'b0000;
    end else if (byteE) begin
      byteMaskE = 4'b0001 << aluResultLowE;
    end else begin
      byteMaskE = 4'b1111;
    end
  end

  // Decoder keeps a store apart from loads and fetch redirects
  storeExclusiveA: assert property (@(posedge clk) disable iff (!rstN)
    memWriteGE |-> !(memtoRegE || branchTakenE || pcSrcGE))
    else $error("Store in Execute also loads or redirects fetch");

endmodule

`default_nettype wire

/* source/retireStages.sv */
`default_nettype none

module retireStages
  import armCtrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallM,
  input  logic       flushM,
  input  logic       stallW,
  input  logic       flushW,
  input  logic       memWriteGE,
  input  logic       regWriteGE,
  input  logic       memtoRegE,
  input  logic       pcSrcGE,
  input  logic       setFlagsE,
  input  flagsT      flagsNextE,
  input  logic [3:0] byteMaskE,
  output logic       memWriteM,
  output logic       regWriteM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW,
  output logic [3:0] byteMaskM,
  output flagsT      flagsM,
  output flagsT      flagsW,
  output logic       setFlagsM,
  output logic       setFlagsW,
  output flagsT      cpsrFlags
);

  logic memtoRegM;
  logic pcSrcM;

  // ====================
  // Memory register
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      memWriteM <= 1'b0;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      flagsM    <= '0;
      byteMaskM <= 4'b0000;
    end else if (!stallM) begin
      memWriteM <= memWriteGE;
      regWriteM <= regWriteGE;
      memtoRegM <= memtoRegE;
      pcSrcM    <= pcSrcGE;
      setFlagsM <= setFlagsE;
      flagsM    <= flagsNextE;  // Also forwarded back to Execute
      byteMaskM <= byteMaskE;
    end
  end

  // ====================
  // Writeback register
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
      flagsW    <= '0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
      flagsW    <= flagsM;
    end
  end

  // Architectural NZCV, committed as the setter leaves Writeback
  always_ff @(posedge clk) begin
    if (!rstN) begin
      cpsrFlags <= '0;
    end else if (setFlagsW && !stallW) begin
      cpsrFlags <= flagsW;
    end
  end

  // Decoder never pairs a store with a register write
  storeNoRegWriteA: assert property (@(posedge clk) disable iff (!rstN)
    memWriteM |-> !regWriteM)
    else $error("Store in Memory also writes a register");

endmodule

`default_nettype wire

/* source/armController.sv */
`default_nettype none

module armController
  import armCtrlPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [instrWidth-1:0] instrD,
  input  flagsT                 aluFlagsE,
  input  logic [1:0]            aluResultLowE,
  input  logic                  stallD,
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushD,
  input  logic                  flushE,
  input  logic                  flushM,
  input  logic                  flushW,
  output logic [1:0]            regSrcD,
  output logic [1:0]            immSrcD,
  output logic                  aluSrcD,
  output aluOpT                 aluControlE,
  output logic                  branchTakenE,
  output logic                  memtoRegE,
  output logic                  memWriteM,
  output logic [3:0]            byteMaskM,
  output logic                  regWriteM,
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  pcSrcW,
  output flagsT                 cpsrFlags
);

  // ====================
  // Decode bundle
  // ====================
  logic  memtoRegD;
  logic  regWriteD;
  logic  memWriteD;
  logic  branchD;
  logic  pcSrcD;
  logic  flagWriteD;
  logic  byteD;
  aluOpT aluControlD;
  condT  condD;

  // Gated Execute controls and flag forwarding paths
  logic       regWriteGE;
  logic       memWriteGE;
  logic       pcSrcGE;
  logic       setFlagsE;
  logic       setFlagsM;
  logic       setFlagsW;
  flagsT      flagsNextE;
  flagsT      flagsM;
  flagsT      flagsW;
  logic [3:0] byteMaskE;

  assign condD = condT'(instrD[condMsb:condLsb]);

  // Port names match the nets above
  instrDecoder decoderI (.*);

  executeStage executeI (.*);

  retireStages retireI (.*);

endmodule

`default_nettype wire

/* test/armControllerTb.sv */
`default_nettype none

module armControllerTb
  import armCtrlPkg::*;
;

  logic        clk;
  logic        rstN;
  logic [31:0] instrD;
  flagsT       aluFlagsE;
  logic [1:0]  aluResultLowE;
  logic        stallD;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushD;
  logic        flushE;
  logic        flushM;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcD;
  aluOpT       aluControlE;
  logic        branchTakenE;
  logic        memtoRegE;
  logic        memWriteM;
  logic [3:0]  byteMaskM;
  logic        regWriteM;
  logic        regWriteW;
  logic        memtoRegW;
  logic        pcSrcW;
  flagsT       cpsrFlags;

  logic [31:0] lfsr;    // Random source state
  int          errors;
  int          checks;

  armController dut_i (.*);

  always #20 clk = ~clk;  // 40 unit period

  // ====================
  // Helpers
  // ====================
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      outBit = lfsr[0];
      lfsr   = lfsr >> 1;
      if (outBit) lfsr = lfsr ^ 32'h8020_0003;
      value  = {value[30:0], outBit};
    end
    return value;
  endfunction

  // Data processing word, rn is r2 and the operand field is imm 3 or r3
  function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic imm,
                                         input logic [3:0] op, input logic s,
                                         input logic [3:0] rd);
    return {cond, 2'b00, imm, op, s, 4'h2, rd, 12'h003};
  endfunction

  // Pre-indexed LDR/STR with a 12-bit immediate offset
  function automatic logic [31:0] memWord(input logic [3:0] cond, input logic load,
                                          input logic byteAcc, input logic up,
                                          input logic [3:0] rd);
    return {cond, 3'b010, 1'b1, up, byteAcc, 1'b0, load, 4'h2, rd, 12'h004};
  endfunction

  function automatic logic [31:0] branchWord(input logic [3:0] cond);
    return {cond, 4'b1010, 24'h000010};
  endfunction

  function automatic logic [31:0] swiWord();
    return {4'hE, 4'hF, 24'h000000};  // SWI decodes to a bubble
  endfunction

  // Expected {regSrc, immSrc, aluSrc} per class
  function automatic logic [4:0] selectsFor(input int cls);
    case (cls)
      0:       return 5'b00_00_1;  // DP immediate
      1:       return 5'b00_00_0;  // DP register
      2:       return 5'b00_01_1;  // LDR
      3:       return 5'b10_01_1;  // STR reads rd
      default: return 5'b01_10_1;  // B
    endcase
  endfunction

  // ARM condition table on NZCV
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n;
    logic z;
    logic c;
    logic v;
    n = nzcv[3];
    z = nzcv[2];
    c = nzcv[1];
    v = nzcv[0];
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && (n == v);
      4'hD: return z || (n != v);
      4'hE: return 1'b1;
      default: return 1'b0;  // nv
    endcase
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                         input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    instrD <= word;
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic resetState();
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    compare(32'(branchTakenE), 32'd0, "branchTakenE after reset");
    compare(32'(memtoRegE), 32'd0, "memtoRegE after reset");
    compare(32'(memWriteM), 32'd0, "memWriteM after reset");
    compare(32'(regWriteM), 32'd0, "regWriteM after reset");
    compare(32'(regWriteW), 32'd0, "regWriteW after reset");
    compare(32'(memtoRegW), 32'd0, "memtoRegW after reset");
    compare(32'(pcSrcW), 32'd0, "pcSrcW after reset");
    compare(32'(byteMaskM), 32'd0, "byteMaskM after reset");
    compare(32'(cpsrFlags), 32'd0, "cpsrFlags after reset");
  endtask

  task automatic decodeClasses();
    logic [31:0] words [5];
    logic [3:0]  aluExp [5];
    logic [3:0]  opA;
    logic [3:0]  opB;
    opA       = 4'(randBits(4));
    opB       = 4'(randBits(4));
    words[0]  = dpWord(4'hE, 1'b1, opA, 1'b0, 4'h1);
    aluExp[0] = opA;                                  // Opcode field straight through
    words[1]  = dpWord(4'hE, 1'b0, opB, 1'b0, 4'h1);
    aluExp[1] = opB;
    words[2]  = memWord(4'hE, 1'b1, 1'b0, 1'b1, 4'h1);
    aluExp[2] = 4'h4;                                 // Up bit set, add
    words[3]  = memWord(4'hE, 1'b0, 1'b0, 1'b0, 4'h1);
    aluExp[3] = 4'h2;                                 // Up bit clear, sub
    words[4]  = branchWord(4'hE);
    aluExp[4] = 4'h4;
    for (int i = 0; i < 5; i++) begin
      issue(words[i]);
      @(negedge clk);
      compare(32'({regSrcD, immSrcD, aluSrcD}), 32'(selectsFor(i)),
              $sformatf("Decode selects for class %0d", i));
      issue(swiWord());
      @(negedge clk);
      compare(32'(aluControlE), 32'(aluExp[i]), $sformatf("aluControlE for class %0d", i));
      compare(32'(memtoRegE), 32'(i == 2), $sformatf("memtoRegE for class %0d", i));
      // Previous word sits in Writeback now
      compare(32'(memtoRegW), 32'(i == 3), $sformatf("memtoRegW before class %0d", i));
    end
  endtask

  task automatic conditionalExec();
    logic [3:0] flagsExp;
    logic       holds;
    flagsExp = 4'(randBits(4));
    issue(dpWord(4'hE, 1'b1, 4'h4, 1'b1, 4'h1));  // ADDS, all four flags from the ALU
    issue(swiWord());
    aluFlagsE <= flagsExp;
    issue(swiWord());
    aluFlagsE <= 4'h0;
    for (int c = 0; c < 16; c++) begin
      holds = condHolds(4'(c), flagsExp);
      issue(dpWord(4'(c), 1'b1, 4'hD, 1'b0, 4'h1));  // MOV{c} r1
      issue(branchWord(4'(c)));
      issue(swiWord());
      @(negedge clk);
      compare(32'(branchTakenE), 32'(holds), $sformatf("branchTakenE for cond %0h", c));
      compare(32'(regWriteM), 32'(holds), $sformatf("regWriteM for cond %0h", c));
      issue(swiWord());
      @(negedge clk);                                // MOV now in Writeback
      compare(32'(regWriteW), 32'(holds), $sformatf("regWriteW for cond %0h", c));
      issue(swiWord());
      @(negedge clk);                                // B now in Writeback
      compare(32'(pcSrcW), 32'(holds), $sformatf("pcSrcW for cond %0h", c));
    end
  endtask

  task automatic flagForwarding();
    logic [3:0] addsFlags;
    logic [3:0] andsFlags;
    logic [3:0] flagsExp;
    logic [3:0] nextFlags;
    int         edges;
    addsFlags = 4'b0011;
    andsFlags = 4'b1100;
    flagsExp  = {andsFlags[3:2], addsFlags[1:0]};  // ANDS keeps C and V
    issue(dpWord(4'hE, 1'b1, 4'h4, 1'b1, 4'h1));   // ADDS
    issue(dpWord(4'hE, 1'b0, 4'h0, 1'b1, 4'h2));   // ANDS
    aluFlagsE <= addsFlags;
    issue(branchWord(4'hA));                       // BGE, needs the kept V
    aluFlagsE <= andsFlags;
    issue(branchWord(4'h4));                       // BMI
    aluFlagsE <= 4'h0;
    @(negedge clk);
    compare(32'(branchTakenE), 32'(condHolds(4'hA, flagsExp)), "BGE with Memory flags");
    issue(branchWord(4'h0));
    @(negedge clk);
    compare(32'(branchTakenE), 32'(condHolds(4'h4, flagsExp)), "BMI with Writeback flags");
    issue(branchWord(4'h1));
    @(negedge clk);
    compare(32'(branchTakenE), 32'(condHolds(4'h0, flagsExp)), "BEQ with cpsrFlags");
    issue(swiWord());
    @(negedge clk);
    compare(32'(branchTakenE), 32'(condHolds(4'h1, flagsExp)), "BNE with cpsrFlags");
    compare(32'(cpsrFlags), 32'(flagsExp), "cpsrFlags after ANDS");

    // Commit latency of a fresh ADDS
    nextFlags = 4'(randBits(4));
    if (nextFlags == flagsExp) nextFlags = ~nextFlags;
    issue(dpWord(4'hE, 1'b1, 4'h4, 1'b1, 4'h1));
    issue(swiWord());                              // ADDS leaves Decode here
    aluFlagsE <= nextFlags;
    edges = 0;
    @(negedge clk);
    while (cpsrFlags !== nextFlags && edges < 8) begin
      @(posedge clk);
      aluFlagsE <= 4'h0;
      edges++;
      @(negedge clk);
    end
    if (cpsrFlags !== nextFlags) begin
      errors++;
      $display("Timed out waiting for cpsrFlags to take the ADDS flags");
    end else begin
      compare(32'(edges), 32'd3, "Edges from Decode to cpsrFlags update");
    end
  endtask

  task automatic stallFlush();
    issue(dpWord(4'hE, 1'b0, 4'h1, 1'b0, 4'h1));  // EOR
    issue(dpWord(4'hE, 1'b0, 4'hC, 1'b0, 4'h1));  // ORR waits in Decode
    stallE <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      @(negedge clk);
      compare(32'(aluControlE), 32'h1, "aluControlE held by stallE");
    end
    @(posedge clk);
    stallE <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare(32'(aluControlE), 32'hC, "aluControlE after stall release");
    issue(memWord(4'hE, 1'b0, 1'b0, 1'b1, 4'h1));  // STR
    flushE <= 1'b1;
    issue(swiWord());
    flushE <= 1'b0;
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      @(negedge clk);
      compare(32'(memWriteM), 32'd0, "memWriteM after flushed STR");
    end
  endtask

  task automatic byteLanes();
    for (int lane = 0; lane < 5; lane++) begin
      issue(memWord(4'hE, 1'b0, lane < 4, 1'b1, 4'h1));  // STRB, then STR
      issue(swiWord());
      aluResultLowE <= 2'(lane);
      issue(swiWord());
      aluResultLowE <= 2'b00;
      @(negedge clk);
      compare(32'(memWriteM), 32'd1, $sformatf("memWriteM for store %0d", lane));
      if (lane < 4) begin
        compare(32'(byteMaskM), 32'd1 << lane, $sformatf("byteMaskM for lane %0d", lane));
      end else begin
        compare(32'(byteMaskM), 32'hF, "byteMaskM for word store");
      end
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    lfsr          = 32'd83176;
    errors        = 0;
    checks        = 0;
    clk           = 1'b0;
    rstN          = 1'b0;
    instrD        = swiWord();
    aluFlagsE     = 4'h0;
    aluResultLowE = 2'b00;
    stallD        = 1'b0;
    stallE        = 1'b0;
    stallM        = 1'b0;
    stallW        = 1'b0;
    flushD        = 1'b0;
    flushE        = 1'b0;
    flushM        = 1'b0;
    flushW        = 1'b0;
    resetState();
    decodeClasses();
    conditionalExec();
    flagForwarding();
    stallFlush();
    byteLanes();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/armCtrlPkg.sv
source/instrDecoder.sv
source/condUnit.sv
source/executeStage.sv
source/retireStages.sv
source/armController.sv
test/armControllerTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = armControllerTb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Some tests failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
